//--- source/isa_pkg.sv
// RISC-V instruction encoding.
// Major opcodes that the fetch predecoder cares about, plus the
// J-type and B-type immediate extraction as signed byte offsets.
package isa_pkg;

    // Major opcode field, bits 6:0 of every instruction.
    typedef logic [6:0] opcode_t;

    // Signed byte offset relative to the instruction's own address.
    typedef logic signed [31:0] offset_t;

    // Unconditional jump and link.
    localparam opcode_t op_jal = 7'b1101111;
    // Conditional branches (BEQ, BNE, BLT, ...).
    localparam opcode_t op_branch = 7'b1100011;

    // Major opcode of a raw instruction word.
    function automatic opcode_t opcode_of(input logic [31:0] word);
        return word[6:0];
    endfunction

    // J-type immediate, 21 bits, sign extended.
    function automatic offset_t j_offset(input logic [31:0] word);
        return {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    endfunction

    // B-type immediate, 13 bits, sign extended.
    function automatic offset_t b_offset(input logic [31:0] word);
        return {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    endfunction

    // Bit 0 of both immediates is implied zero.
    // Bit 1 is always zero too without compressed instructions, so the
    // word offset is simply bits 31:2 of these values.

endpackage

//--- source/fetch_pkg.sv
// Fetch front end types.
// Word addresses, instruction words and the states of the fetch
// controller.
package fetch_pkg;

    // Word address, byte address bits 31:2.
    // Used for the program counter, memory address and redirect target.
    typedef logic [31:2] addr_t;

    // Raw 32-bit instruction word.
    typedef logic [31:0] insn_t;

    // Fetch controller states.
    // Two-state base type so the machine powers up in st_boot.
    typedef enum bit [1:0] {
        // First cycle after reset, no request yet.
        st_boot = 2'd0,
        // Normal sequential or predicted fetch.
        st_fetch = 2'd1,
        // Bubble after a back end redirect.
        st_redirect = 2'd2
    } ctrl_state_t;

    // Distance between consecutive instructions, in words.
    localparam addr_t addr_step = 30'd1;

endpackage

//--- source/fetch_push_if.sv
// Push channel from the predecoder into the instruction queue.
// One fetched instruction per cycle, qualified by push.
`timescale 1ns/1ps

interface fetch_push_if;

    // Entry is valid this cycle.
    logic push;
    // Word address the instruction was fetched from.
    fetch_pkg::addr_t pc;
    // Instruction word as returned by program memory.
    fetch_pkg::insn_t insn;
    // Predecode sent fetch to the predicted target after this one.
    logic predicted;

    // Predecoder side.
    modport src (
        output push,
        output pc,
        output insn,
        output predicted
    );

    // Queue side.
    modport dst (
        input push,
        input pc,
        input insn,
        input predicted
    );

endinterface

//--- source/fetch_ctrl.sv
// Fetch controller.
// Sequences boot, normal fetch and the bubble after a redirect, and
// decides when a program memory request goes out and is accepted.
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic redirect_valid,
    input  logic mem_ready,
    input  logic room,
    output logic mem_re,
    output logic accept,
    output logic flush
);

    fetch_pkg::ctrl_state_t state_q;
    fetch_pkg::ctrl_state_t state_d;

    // Next state.
    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::st_boot: begin
                state_d = fetch_pkg::st_fetch;
            end
            fetch_pkg::st_fetch: begin
                state_d = fetch_pkg::st_fetch;
            end
            fetch_pkg::st_redirect: begin
                // One bubble only.
                state_d = fetch_pkg::st_fetch;
            end
            default: begin
                state_d = fetch_pkg::st_boot;
            end
        endcase
        // A redirect always wins, from any state.
        if (redirect_valid) begin
            state_d = fetch_pkg::st_redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= fetch_pkg::st_boot;
        end else begin
            state_q <= state_d;
        end
    end

    // Request only when fetching, with a free slot, and not while the pc
    // is being replaced.
    assign mem_re = (state_q == fetch_pkg::st_fetch) && room && !redirect_valid;

    // Memory returns the word in the cycle it raises ready.
    assign accept = mem_re && mem_ready;

    // Redirect throws away the queue and reloads the pc.
    assign flush = redirect_valid;

    // No request may leave while reset is held.
    assert property (@(posedge clk) rst |-> !mem_re)
        else $error("MISMATCH mem_re expected 0x0 actual 0x%h during rst", mem_re);

    // Boot cycle right after reset is still quiet.
    assert property (@(posedge clk) $fell(rst) |-> !mem_re)
        else $error("MISMATCH mem_re expected 0x0 actual 0x%h after rst", mem_re);

endmodule

//--- source/pc_gen.sv
// Program counter.
// Holds the current fetch address and picks the next one from reset,
// redirect, predicted target or the sequential address.
`timescale 1ns/1ps

module pc_gen #(
    // Byte address 0x4000_0000 as a word address.
    parameter fetch_pkg::addr_t entrypoint = fetch_pkg::addr_t'(32'h4000_0000 >> 2)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             accept,
    input  logic             predict_taken,
    input  fetch_pkg::addr_t predict_target,
    output fetch_pkg::addr_t pc
);

    fetch_pkg::addr_t pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= entrypoint;
        end else if (flush) begin
            // Back end correction overrides anything fetched.
            pc_q <= redirect_pc;
        end else if (accept && predict_taken) begin
            // Follow the predecoder's guess.
            pc_q <= predict_target;
        end else if (accept) begin
            pc_q <= pc_q + fetch_pkg::addr_step;
        end
        // Otherwise hold and repeat the request.
    end

    assign pc = pc_q;

endmodule

//--- source/branch_predecode.sv
// Branch predecoder.
// Looks at the word returned by program memory, predicts JAL and
// backward conditional branches as taken, computes the target and
// pushes the instruction into the queue on accept.
`timescale 1ns/1ps

module branch_predecode (
    input  logic             accept,
    input  fetch_pkg::addr_t pc,
    input  fetch_pkg::insn_t rdata,
    fetch_push_if.src        push,
    output logic             predict_taken,
    output fetch_pkg::addr_t predict_target
);

    isa_pkg::opcode_t opcode;
    isa_pkg::offset_t offset;
    logic             is_jal;
    logic             is_branch;

    always_comb begin
        opcode    = isa_pkg::opcode_of(rdata);
        is_jal    = (opcode == isa_pkg::op_jal);
        is_branch = (opcode == isa_pkg::op_branch);

        // Pick the immediate format from the opcode.
        if (is_jal) begin
            offset = isa_pkg::j_offset(rdata);
        end else begin
            offset = isa_pkg::b_offset(rdata);
        end

        // Jumps always, branches only backward (loops).
        predict_taken = is_jal || (is_branch && offset[31]);

        // Offset in words, added modulo the address width.
        predict_target = pc + fetch_pkg::addr_t'(offset[31:2]);
    end

    // Entry into the queue.
    assign push.push      = accept;
    assign push.pc        = pc;
    assign push.insn      = rdata;
    assign push.predicted = predict_taken;

endmodule

//--- source/fetch_queue.sv
// Instruction queue.
// Circular buffer between fetch and decode. Entries go out one per
// cycle against credits that the decode stage hands back.
`timescale 1ns/1ps

module fetch_queue #(
    parameter int queue_depth    = 4,
    parameter int decode_credits = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    fetch_push_if.dst        push,
    output logic             room,
    input  logic             credit_return,
    output logic             out_valid,
    output fetch_pkg::addr_t out_pc,
    output fetch_pkg::insn_t out_insn,
    output logic             out_predicted
);

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);
    localparam int crd_w = $clog2(decode_credits + 1);

    // Entry storage.
    fetch_pkg::addr_t pc_mem   [queue_depth];
    fetch_pkg::insn_t insn_mem [queue_depth];
    logic             pred_mem [queue_depth];

    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [cnt_w-1:0] count;
    logic [crd_w-1:0] credits;
    logic             pop;

    // Pointer increment with wrap for any depth.
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(queue_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign room = (count != cnt_w'(queue_depth));

    // Head goes out when there is one, a credit is held and no flush.
    assign out_valid     = (count != '0) && (credits != '0) && !flush;
    assign pop           = out_valid;
    assign out_pc        = pc_mem[head];
    assign out_insn      = insn_mem[head];
    assign out_predicted = pred_mem[head];

    always_ff @(posedge clk) begin
        if (push.push) begin
            pc_mem[tail]   <= push.pc;
            insn_mem[tail] <= push.insn;
            pred_mem[tail] <= push.predicted;
        end
    end

    // Occupancy and pointers.
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push.push) begin
                tail <= next_ptr(tail);
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            count <= count + cnt_w'(push.push) - cnt_w'(pop);
        end
    end

    // Credit counter, kept across flushes.
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= crd_w'(decode_credits);
        end else begin
            credits <= credits + crd_w'(credit_return) - crd_w'(pop);
        end
    end

    // Controller must not accept into a full queue.
    assert property (@(posedge clk) disable iff (rst)
        push.push |-> (count != cnt_w'(queue_depth)))
        else $error("MISMATCH count expected <0x%h actual 0x%h on push",
                    queue_depth, count);

    // Decode may never return more credits than it was given.
    assert property (@(posedge clk) disable iff (rst)
        credits <= crd_w'(decode_credits))
        else $error("MISMATCH credits expected <=0x%h actual 0x%h",
                    decode_credits, credits);

endmodule

//--- source/fetch_unit.sv
// Instruction fetch front end.
// Controller, program counter, branch predecoder and instruction queue
// between program memory, the back end redirect and the decode stage.
`timescale 1ns/1ps

module fetch_unit #(
    // Word address of the first instruction (byte address 0x4000_0000).
    parameter fetch_pkg::addr_t entrypoint     = fetch_pkg::addr_t'(32'h4000_0000 >> 2),
    parameter int               queue_depth    = 4,
    parameter int               decode_credits = 2
) (
    input  logic             clk,
    input  logic             rst,

    // Program memory read port.
    output logic             mem_re,
    output fetch_pkg::addr_t mem_addr,
    input  fetch_pkg::insn_t mem_rdata,
    input  logic             mem_ready,

    // Back end redirect.
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,

    // Decode side.
    output logic             out_valid,
    output fetch_pkg::addr_t out_pc,
    output fetch_pkg::insn_t out_insn,
    output logic             out_predicted,
    input  logic             credit_return
);

    logic             accept;
    logic             flush;
    logic             room;
    logic             predict_taken;
    fetch_pkg::addr_t predict_target;

    fetch_push_if push_bus ();

    fetch_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .mem_ready      (mem_ready),
        .room           (room),
        .mem_re         (mem_re),
        .accept         (accept),
        .flush          (flush)
    );

    // The pc is the memory address directly.
    pc_gen #(
        .entrypoint (entrypoint)
    ) u_pc (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .redirect_pc    (redirect_pc),
        .accept         (accept),
        .predict_taken  (predict_taken),
        .predict_target (predict_target),
        .pc             (mem_addr)
    );

    branch_predecode u_predecode (
        .accept         (accept),
        .pc             (mem_addr),
        .rdata          (mem_rdata),
        .push           (push_bus.src),
        .predict_taken  (predict_taken),
        .predict_target (predict_target)
    );

    fetch_queue #(
        .queue_depth    (queue_depth),
        .decode_credits (decode_credits)
    ) u_queue (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .push           (push_bus.dst),
        .room           (room),
        .credit_return  (credit_return),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_insn       (out_insn),
        .out_predicted  (out_predicted)
    );

endmodule

//--- sim/fetch_unit_tb.sv
// Testbench for the instruction fetch front end.
// Program memory with random ready, a decode stage that returns credits
// after random gaps, and random back end redirects.
`timescale 1ns/1ps

module fetch_unit_tb;

    localparam fetch_pkg::addr_t entry = fetch_pkg::addr_t'(32'h4000_0000 >> 2);
    localparam int depth        = 4;
    localparam int credit_limit = 2;
    // Branch slots inside every 64-word block, offsets in words.
    localparam logic [5:0] jal_slot = 6'h0f;
    localparam logic [5:0] bwd_slot = 6'h27;
    localparam logic [5:0] fwd_slot = 6'h33;
    localparam int jal_words = 32;
    localparam int bwd_words = -27;
    localparam int fwd_words = 4;

    logic             clk;
    logic             rst;
    logic             mem_re;
    fetch_pkg::addr_t mem_addr;
    fetch_pkg::insn_t mem_rdata;
    logic             mem_ready;
    logic             redirect_valid;
    fetch_pkg::addr_t redirect_pc;
    logic             out_valid;
    fetch_pkg::addr_t out_pc;
    fetch_pkg::insn_t out_insn;
    logic             out_predicted;
    logic             credit_return;

    // Reference state, updated on every rising edge.
    fetch_pkg::addr_t exp_pc;
    int outstanding = 0;
    int occupancy   = 0;
    int out_count   = 0;
    int redirects   = 0;
    // Run bookkeeping.
    int errors        = 0;
    int phase_errors  = 0;
    int phases_passed = 0;
    int phases_failed = 0;
    int gap           = 0;
    logic hold_credits = 1'b0;
    logic redirect_on  = 1'b0;
    logic timed_out    = 1'b0;

    fetch_unit #(
        .entrypoint     (entry),
        .queue_depth    (depth),
        .decode_credits (credit_limit)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // JAL, rd = x1, byte offset.
    function automatic fetch_pkg::insn_t jal_insn(input int off);
        logic [31:0] o;
        o = off;
        return {o[20], o[10:1], o[11], o[19:12], 5'd1, isa_pkg::op_jal};
    endfunction

    // BNE x1, x2, byte offset.
    function automatic fetch_pkg::insn_t branch_insn(input int off);
        logic [31:0] o;
        o = off;
        return {o[12], o[10:5], 5'd2, 5'd1, 3'b001, o[4:1], o[11], isa_pkg::op_branch};
    endfunction

    // Program image. Filler is an ADDI whose upper bits hash the address.
    function automatic fetch_pkg::insn_t word_at(input fetch_pkg::addr_t a);
        logic [31:0] h;
        h = {2'b00, a} * 32'h9e37_79b1;
        case (a[5:0])
            jal_slot: return jal_insn(jal_words * 4);
            bwd_slot: return branch_insn(bwd_words * 4);
            fwd_slot: return branch_insn(fwd_words * 4);
            default:  return {h[31:7], 7'b0010011};
        endcase
    endfunction

    // JAL and the backward branch are the predicted slots.
    function automatic logic predicted_at(input fetch_pkg::addr_t a);
        return (a[5:0] == jal_slot) || (a[5:0] == bwd_slot);
    endfunction

    function automatic fetch_pkg::addr_t target_at(input fetch_pkg::addr_t a);
        if (a[5:0] == jal_slot) begin
            return a + fetch_pkg::addr_t'(jal_words);
        end
        return a + fetch_pkg::addr_t'(bwd_words);
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("MISMATCH %s expected 0x%h actual 0x%h", sig, expected, actual);
    endtask

    // Expected next pc, credits in flight and queue fill.
    always @(posedge clk) begin
        if (rst) begin
            exp_pc      <= entry;
            outstanding <= 0;
            occupancy   <= 0;
        end else begin
            outstanding <= outstanding + (out_valid ? 1 : 0) - (credit_return ? 1 : 0);
            out_count   <= out_count + (out_valid ? 1 : 0);
            if (redirect_valid) begin
                // Queue emptied, fetch restarts at the new target.
                exp_pc    <= redirect_pc;
                occupancy <= 0;
                redirects <= redirects + 1;
            end else begin
                occupancy <= occupancy + int'(mem_re && mem_ready) - (out_valid ? 1 : 0);
                if (out_valid) begin
                    exp_pc <= predicted_at(out_pc) ? target_at(out_pc)
                                                   : out_pc + fetch_pkg::addr_t'(1);
                end
            end
        end
    end

    assert property (@(posedge clk) rst |-> !mem_re)
        else report_mismatch("mem_re", 32'h0, 32'(mem_re));
    // First request on the second cycle after reset, at the entry point.
    assert property (@(posedge clk) $fell(rst) |=> mem_re)
        else report_mismatch("mem_re", 32'h1, 32'(mem_re));
    assert property (@(posedge clk) $fell(rst) |=> mem_addr == entry)
        else report_mismatch("mem_addr", 32'(entry), 32'(mem_addr));
    // Order of outputs, no skip and no repeat.
    assert property (@(posedge clk) disable iff (rst) out_valid |-> out_pc == exp_pc)
        else report_mismatch("out_pc", 32'(exp_pc), 32'(out_pc));
    assert property (@(posedge clk) disable iff (rst) out_valid |-> out_insn == word_at(out_pc))
        else report_mismatch("out_insn", word_at(out_pc), out_insn);
    assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_predicted == predicted_at(out_pc))
        else report_mismatch("out_predicted", 32'(predicted_at(out_pc)), 32'(out_predicted));
    // Credit protocol.
    assert property (@(posedge clk) disable iff (rst) outstanding <= credit_limit)
        else report_mismatch("outstanding", 32'(credit_limit), 32'(outstanding));
    assert property (@(posedge clk) disable iff (rst)
        outstanding == credit_limit |-> !out_valid)
        else report_mismatch("out_valid", 32'h0, 32'(out_valid));
    assert property (@(posedge clk) disable iff (rst) redirect_valid |-> !out_valid)
        else report_mismatch("out_valid", 32'h0, 32'(out_valid));
    // Full queue stops requests.
    assert property (@(posedge clk) disable iff (rst) occupancy == depth |-> !mem_re)
        else report_mismatch("mem_re", 32'h0, 32'(mem_re));

    // Memory, redirect and consumer stimulus for one cycle.
    task automatic drive_inputs();
        mem_ready      = ($urandom_range(2, 0) != 0);
        mem_rdata      = word_at(mem_addr);
        redirect_valid = redirect_on && ($urandom_range(39, 0) == 0);
        redirect_pc    = entry + fetch_pkg::addr_t'($urandom_range(191, 0));
        credit_return  = 1'b0;
        if (gap > 0) begin
            gap = gap - 1;
        end else if (!hold_credits && outstanding > 0 && $urandom_range(3, 0) != 0) begin
            credit_return = 1'b1;
            // Decode stalls for a long while now and then.
            if ($urandom_range(19, 0) == 0) begin
                gap = $urandom_range(30, 10);
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        drive_inputs();
    endtask

    task automatic wait_outputs(input int n, input string what);
        int target;
        int waited;
        target = out_count + n;
        waited = 0;
        while (out_count < target && waited < 5000) begin
            next_cycle();
            waited++;
        end
        if (out_count < target) begin
            $display("Timeout: %s got no output for %0d cycles", what, waited);
            timed_out = 1'b1;
        end
    endtask

    // Queue full and every credit spent.
    task automatic wait_full();
        int waited;
        waited = 0;
        while ((occupancy != depth || outstanding != credit_limit) && waited < 500) begin
            next_cycle();
            waited++;
        end
        if (occupancy != depth || outstanding != credit_limit) begin
            $display("Timeout: queue did not fill while credits were withheld");
            timed_out = 1'b1;
        end
    endtask

    task automatic end_phase(input string name);
        if (timed_out) begin
            $display("FAIL  %s, timed out", name);
            phases_failed++;
        end else if (errors == phase_errors) begin
            $display("PASS  %s", name);
            phases_passed++;
        end else begin
            $display("FAIL  %s, %0d failed checks", name, errors - phase_errors);
            phases_failed++;
        end
        phase_errors = errors;
    endtask

    // Phases in order, stopping at the first timeout.
    task automatic run_phases();
        wait_outputs(1, "first fetch");
        end_phase("reset and first fetch at entry point");
        if (timed_out) begin
            return;
        end
        wait_outputs(120, "sequential fetch");
        end_phase("sequential and predicted fetch");
        if (timed_out) begin
            return;
        end
        redirect_on = 1'b1;
        wait_outputs(200, "fetch with redirects");
        redirect_on = 1'b0;
        end_phase("random redirects");
        if (timed_out) begin
            return;
        end
        hold_credits = 1'b1;
        wait_full();
        if (!timed_out) begin
            repeat (20) next_cycle();
            hold_credits = 1'b0;
            wait_outputs(40, "fetch after back-pressure");
        end
        end_phase("credit back-pressure");
    endtask

    initial begin
        void'($urandom(32'h00af3483));
        rst            = 1'b1;
        mem_rdata      = '0;
        mem_ready      = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        credit_return  = 1'b0;
        // Two rising edges in reset.
        repeat (2) @(posedge clk);
        next_cycle();
        rst = 1'b0;
        run_phases();
        $display("Phases passed %0d, failed %0d, failed checks %0d, redirects %0d",
                 phases_passed, phases_failed, errors, redirects);
        if (errors == 0 && phases_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- fetch_unit.f
source/isa_pkg.sv
source/fetch_pkg.sv
source/fetch_push_if.sv
source/fetch_ctrl.sv
source/pc_gen.sv
source/branch_predecode.sv
source/fetch_queue.sv
source/fetch_unit.sv
sim/fetch_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the fetch unit testbench with Verilator, run it, check the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module fetch_unit_tb -f fetch_unit.f \
    && ./obj_dir/Vfetch_unit_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
